// ==== src/mem_req_pkg.sv ====
package mem_req_pkg;

	// ========================================
	// Widths and depths
	// ========================================

	// Word address into the local RAM
	localparam int ADDR_W = 10;

	// Data word carried by both read and write traffic
	localparam int DATA_W = 32;

	// The RAM covers the whole address space
	localparam int RAM_DEPTH = 1 << ADDR_W;

	// Queue depths, each queue holds one entry less than its depth
	localparam int FETCH_QDEPTH = 8;
	localparam int LS_QDEPTH = 16;

	// A fetch entry is the bare address
	localparam int FETCH_ENTRY_W = ADDR_W;

	// Load/store entry from the top bit down is write flag, address, write data
	localparam int LS_ENTRY_W = 1 + ADDR_W + DATA_W;

	// Almost-full rises once the count exceeds depth minus this margin
	localparam int ALMOST_FULL_MARGIN = 6;

	// ========================================
	// Types
	// ========================================

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [FETCH_ENTRY_W-1:0] fetch_entry_t;
	typedef logic [LS_ENTRY_W-1:0] ls_entry_t;

	// Source of the last grant and of a read in flight
	typedef enum logic {GRANT_FETCH = 1'b0, GRANT_LS = 1'b1} grant_t;

endpackage

// ==== src/req_fifo.sv ====
module req_fifo #(
	parameter int WID = 10,
	parameter int DEP = 8
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           wr,
	input  logic [WID-1:0] di,
	input  logic           rd,
	output logic [WID-1:0] dout,
	output logic           almost_full,
	output logic           full,
	output logic           empty
);

	// Pointers wrap naturally, so DEP is expected to be a power of two
	localparam int PTR_W = $clog2(DEP);

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] cnt;
	logic             push;
	logic             pop;

	// Circular buffer held in distributed memory
	logic [WID-1:0] mem [DEP];

	// ========================================
	// Pointer and storage update
	// ========================================

	// A push while full and a pop while empty are both ignored
	assign push = wr && !full;
	assign pop = rd && !empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr + PTR_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + PTR_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= di;
		end
	end

	// Fall-through head, the entry is visible as soon as it is written
	assign dout = rst ? '0 : mem[rd_ptr];

	// ========================================
	// Occupancy flags
	// ========================================

	// Pointer distance modulo DEP
	assign cnt = wr_ptr - rd_ptr;

	// Full is flagged one entry early so the write pointer never laps the read pointer
	assign full = cnt == PTR_W'(DEP - 1);
	assign empty = cnt == '0;
	assign almost_full = int'(cnt) > DEP - mem_req_pkg::ALMOST_FULL_MARGIN;

	// A write into a full queue that is not drained leaves the count at its ceiling
	a_cnt_ceiling: assert property (@(posedge clk) disable iff (rst)
		full && wr && !rd |=> cnt == PTR_W'(DEP - 1));

	// Nothing leaves the queue while it is empty, whatever the arbiter asks for
	a_rd_ptr_hold: assert property (@(posedge clk) disable iff (rst)
		empty |=> rd_ptr == $past(rd_ptr));

endmodule

// ==== src/req_arbiter.sv ====
module req_arbiter (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      fetch_empty,
	input  mem_req_pkg::fetch_entry_t fetch_head,
	output logic                      fetch_pop,
	input  logic                      ls_empty,
	input  mem_req_pkg::ls_entry_t    ls_head,
	output logic                      ls_pop,
	output logic                      ram_en,
	output logic                      ram_we,
	output mem_req_pkg::addr_t        ram_addr,
	output mem_req_pkg::word_t        ram_wdata,
	output logic                      fetch_rvalid,
	output logic                      ls_rvalid
);

	mem_req_pkg::grant_t last_grant;
	mem_req_pkg::grant_t ram_src;
	logic                pop_any;
	logic                ls_we_f;
	mem_req_pkg::addr_t  ls_addr_f;
	mem_req_pkg::word_t  ls_wdata_f;

	// ========================================
	// Round-robin selection
	// ========================================

	// Fetch wins when it is alone or when load/store had the last grant
	assign fetch_pop = !fetch_empty && (ls_empty || last_grant == mem_req_pkg::GRANT_LS);
	assign ls_pop = !ls_empty && !fetch_pop;
	assign pop_any = fetch_pop || ls_pop;

	// Unpack the load/store head
	assign ls_we_f = ls_head[mem_req_pkg::LS_ENTRY_W-1];
	assign ls_addr_f = ls_head[mem_req_pkg::DATA_W +: mem_req_pkg::ADDR_W];
	assign ls_wdata_f = ls_head[mem_req_pkg::DATA_W-1:0];

	// ========================================
	// RAM command register
	// ========================================

	// Control side of the command, the RAM acts on it one edge later
	always_ff @(posedge clk) begin
		if (rst) begin
			ram_en <= 1'b0;
			ram_we <= 1'b0;
			last_grant <= mem_req_pkg::GRANT_LS;
		end else begin
			ram_en <= pop_any;
			ram_we <= ls_pop && ls_we_f;
			if (pop_any) begin
				last_grant <= fetch_pop ? mem_req_pkg::GRANT_FETCH : mem_req_pkg::GRANT_LS;
			end
		end
	end

	// Address, data and source tag only matter while ram_en is high
	always_ff @(posedge clk) begin
		if (pop_any) begin
			ram_addr <= fetch_pop ? mem_req_pkg::addr_t'(fetch_head) : ls_addr_f;
			ram_wdata <= ls_wdata_f;
			ram_src <= fetch_pop ? mem_req_pkg::GRANT_FETCH : mem_req_pkg::GRANT_LS;
		end
	end

	// ========================================
	// Read return routing
	// ========================================

	// The tag follows the read through the RAM cycle while the next command issues
	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_rvalid <= 1'b0;
			ls_rvalid <= 1'b0;
		end else begin
			fetch_rvalid <= ram_en && !ram_we && ram_src == mem_req_pkg::GRANT_FETCH;
			ls_rvalid <= ram_en && !ram_we && ram_src == mem_req_pkg::GRANT_LS;
		end
	end

	// A queue passed over while it waited is served in the very next cycle
	a_fetch_turn: assert property (@(posedge clk) disable iff (rst)
		ls_pop && !fetch_empty |=> fetch_pop);

	a_ls_turn: assert property (@(posedge clk) disable iff (rst)
		fetch_pop && !ls_empty |=> ls_pop);

	// Each return pulse belongs to a read popped from the same queue two edges earlier
	a_fetch_return: assert property (@(posedge clk) disable iff (rst)
		fetch_rvalid |-> $past(fetch_pop, 2));

	a_ls_return: assert property (@(posedge clk) disable iff (rst)
		ls_rvalid |-> $past(ls_pop && !ls_we_f, 2));

endmodule

// ==== src/local_ram.sv ====
module local_ram (
	input  logic               clk,
	input  logic               en,
	input  logic               we,
	input  mem_req_pkg::addr_t addr,
	input  mem_req_pkg::word_t wdata,
	output mem_req_pkg::word_t rdata
);

	// One word per address, single port shared by reads and writes
	mem_req_pkg::word_t mem [mem_req_pkg::RAM_DEPTH];

	// Contents start out cleared
	initial begin
		for (int i = 0; i < mem_req_pkg::RAM_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// ========================================
	// Write port
	// ========================================

	always @(posedge clk) begin
		if (en && we) begin
			mem[addr] <= wdata;
		end
	end

	// ========================================
	// Registered read port
	// ========================================

	// Read data lands one edge after the command and holds until the next read
	always_ff @(posedge clk) begin
		if (en && !we) begin
			rdata <= mem[addr];
		end
	end

endmodule

// ==== src/mem_req_top.sv ====
module mem_req_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               fetch_req,
	input  mem_req_pkg::addr_t fetch_addr,
	output logic               fetch_full,
	output logic               fetch_almost_full,
	input  logic               ls_req,
	input  logic               ls_we,
	input  mem_req_pkg::addr_t ls_addr,
	input  mem_req_pkg::word_t ls_wdata,
	output logic               ls_full,
	output logic               ls_almost_full,
	output mem_req_pkg::word_t rdata,
	output logic               fetch_rvalid,
	output logic               ls_rvalid
);

	// ========================================
	// Queue entries and flags
	// ========================================

	mem_req_pkg::fetch_entry_t fetch_entry;
	mem_req_pkg::fetch_entry_t fetch_head;
	mem_req_pkg::ls_entry_t    ls_entry;
	mem_req_pkg::ls_entry_t    ls_head;
	logic                      fetch_empty;
	logic                      fetch_pop;
	logic                      ls_empty;
	logic                      ls_pop;

	// RAM command from the arbiter
	logic                      ram_en;
	logic                      ram_we;
	mem_req_pkg::addr_t        ram_addr;
	mem_req_pkg::word_t        ram_wdata;

	// A fetch entry is just the address
	assign fetch_entry = fetch_addr;

	// Write flag on top, then address, then write data
	assign ls_entry = {ls_we, ls_addr, ls_wdata};

	req_fifo #(
		.WID(mem_req_pkg::FETCH_ENTRY_W),
		.DEP(mem_req_pkg::FETCH_QDEPTH)
	) fetch_q_i (
		.clk(clk),
		.rst(rst),
		.wr(fetch_req),
		.di(fetch_entry),
		.rd(fetch_pop),
		.dout(fetch_head),
		.almost_full(fetch_almost_full),
		.full(fetch_full),
		.empty(fetch_empty)
	);

	req_fifo #(
		.WID(mem_req_pkg::LS_ENTRY_W),
		.DEP(mem_req_pkg::LS_QDEPTH)
	) ls_q_i (
		.clk(clk),
		.rst(rst),
		.wr(ls_req),
		.di(ls_entry),
		.rd(ls_pop),
		.dout(ls_head),
		.almost_full(ls_almost_full),
		.full(ls_full),
		.empty(ls_empty)
	);

	// ========================================
	// Arbitration and storage
	// ========================================

	req_arbiter arb_i (
		.clk(clk),
		.rst(rst),
		.fetch_empty(fetch_empty),
		.fetch_head(fetch_head),
		.fetch_pop(fetch_pop),
		.ls_empty(ls_empty),
		.ls_head(ls_head),
		.ls_pop(ls_pop),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.fetch_rvalid(fetch_rvalid),
		.ls_rvalid(ls_rvalid)
	);

	// Read data is shared, the rvalid pulses say whose it is
	local_ram ram_i (
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(rdata)
	);

endmodule

// ==== verif/tb_mem_req.sv ====
module tb_mem_req;

	timeunit 1ns;
	timeprecision 1ps;

	logic               clk;
	logic               rst;
	logic               fetch_req;
	mem_req_pkg::addr_t fetch_addr;
	logic               fetch_full;
	logic               fetch_almost_full;
	logic               ls_req;
	logic               ls_we;
	mem_req_pkg::addr_t ls_addr;
	mem_req_pkg::word_t ls_wdata;
	logic               ls_full;
	logic               ls_almost_full;
	mem_req_pkg::word_t rdata;
	logic               fetch_rvalid;
	logic               ls_rvalid;

	// Stimulus lines, port 2 closes a phase
	int                 line_phase[$];
	int                 line_port[$];
	int                 line_we[$];
	mem_req_pkg::addr_t line_addr[$];
	mem_req_pkg::word_t line_data[$];

	// Shadow of the RAM and expected read data per port in push order
	mem_req_pkg::word_t shadow[mem_req_pkg::RAM_DEPTH];
	mem_req_pkg::word_t fetch_exp[$];
	mem_req_pkg::word_t ls_exp[$];

	int cycles = 0;
	int cycle_limit = 200;
	int seed = 47;
	int lone_cycle = -1;
	bit lone_taken = 1'b0;
	int fetch_reads = 0;
	int ls_reads = 0;
	int fetch_returns = 0;
	int ls_returns = 0;
	int fetch_drops = 0;
	int ls_drops = 0;

	mem_req_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Cycle count doubles as the run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the traffic never drained", cycles);
			stop_with_failure();
		end
	end

	// ========================================
	// Failure reporting
	// ========================================

	task automatic stop_with_failure();
		$display("test failed");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	// ========================================
	// Return monitor
	// ========================================

	// Outputs change on the rising edge, so they are sampled on the falling one
	always @(negedge clk) begin
		if (!rst && fetch_rvalid) begin
			if (fetch_exp.size() == 0) begin
				$display("fetch_rvalid pulsed at %0t ns with no fetch read outstanding", $time);
				stop_with_failure();
			end else begin
				check_value("rdata on fetch_rvalid", fetch_exp.pop_front(), rdata);
				fetch_returns++;
				// Push edge, pop edge, RAM edge, then the pulse is visible
				if (lone_cycle >= 0) begin
					check_value("fetch_rvalid latency", 3, cycles - lone_cycle);
					lone_cycle = -1;
				end
			end
		end
		if (!rst && ls_rvalid) begin
			if (ls_exp.size() == 0) begin
				$display("ls_rvalid pulsed at %0t ns with no load read outstanding", $time);
				stop_with_failure();
			end else begin
				check_value("rdata on ls_rvalid", ls_exp.pop_front(), rdata);
				ls_returns++;
			end
		end
	end

	// ========================================
	// Request drivers
	// ========================================

	task automatic idle_inputs();
		fetch_req = 1'b0;
		fetch_addr = '0;
		ls_req = 1'b0;
		ls_we = 1'b0;
		ls_addr = '0;
		ls_wdata = '0;
	endtask

	// Full seen at the driving edge decides whether the push lands
	task automatic push_fetch(mem_req_pkg::addr_t addr);
		fetch_req = 1'b1;
		fetch_addr = addr;
		if (fetch_full) begin
			fetch_drops++;
		end else begin
			fetch_exp.push_back(shadow[addr]);
			fetch_reads++;
			// The very first fetch read meets empty queues and gets the bare latency
			if (!lone_taken) begin
				lone_cycle = cycles;
				lone_taken = 1'b1;
			end
		end
	endtask

	task automatic push_ls(bit we, mem_req_pkg::addr_t addr, mem_req_pkg::word_t data);
		ls_req = 1'b1;
		ls_we = we;
		ls_addr = addr;
		ls_wdata = data;
		if (ls_full) begin
			ls_drops++;
		end else if (we) begin
			shadow[addr] = data;
		end else begin
			ls_exp.push_back(shadow[addr]);
			ls_reads++;
		end
	endtask

	task automatic issue_line(int i);
		if (line_port[i] == 0) begin
			push_fetch(line_addr[i]);
		end else begin
			push_ls(line_we[i] != 0, line_addr[i], line_data[i]);
		end
	endtask

	task automatic read_stimulus();
		int                 fd;
		int                 n;
		int                 port;
		int                 we;
		mem_req_pkg::addr_t addr;
		mem_req_pkg::word_t data;
		string              tok;
		string              rest;
		bit                 done;
		fd = $fopen("verif/mem_req_input.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/mem_req_input.txt");
			stop_with_failure();
		end
		done = 1'b0;
		while (!done) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1) begin
				done = 1'b1;
			end else if (tok == "#") begin
				n = $fgets(rest, fd);
			end else begin
				n = $fscanf(fd, "%d %d %h %h", port, we, addr, data);
				if (n != 4) begin
					$display("malformed stimulus line starting with %s", tok);
					stop_with_failure();
				end
				line_phase.push_back(tok.atoi());
				line_port.push_back(port);
				line_we.push_back(we);
				line_addr.push_back(addr);
				line_data.push_back(data);
			end
		end
		$fclose(fd);
	endtask

	// Idle until both queues are empty, then let the last command pass the RAM
	// edge and the return edge before the returns are counted
	task automatic wait_drained();
		while (!(dut_i.fetch_empty && dut_i.ls_empty)) begin
			@(negedge clk);
		end
		repeat (2) begin
			@(negedge clk);
		end
		check_value("fetch return count", fetch_reads, fetch_returns);
		check_value("ls return count", ls_reads, ls_returns);
	endtask

	// Flood lines are templates, each cycle takes the next one and steps its address
	task automatic run_flood(inout int idx);
		int fetch_tpl[$];
		int ls_tpl[$];
		int k;
		int t;
		int settle;
		int fetch_af_at;
		int fetch_full_at;
		int ls_af_at;
		int ls_full_at;
		while (line_port[idx] != 2) begin
			if (line_port[idx] == 0) begin
				fetch_tpl.push_back(idx);
			end else begin
				ls_tpl.push_back(idx);
			end
			idx++;
		end
		k = 0;
		settle = 0;
		fetch_af_at = -1;
		fetch_full_at = -1;
		ls_af_at = -1;
		ls_full_at = -1;
		// Keep pushing for a while after both queues have filled so some pushes get dropped
		while (settle < 8) begin
			@(negedge clk);
			idle_inputs();
			if (fetch_almost_full && fetch_af_at < 0) fetch_af_at = cycles;
			if (fetch_full && fetch_full_at < 0) fetch_full_at = cycles;
			if (ls_almost_full && ls_af_at < 0) ls_af_at = cycles;
			if (ls_full && ls_full_at < 0) ls_full_at = cycles;
			t = fetch_tpl[k % fetch_tpl.size()];
			push_fetch(line_addr[t] + mem_req_pkg::addr_t'(k / fetch_tpl.size()));
			t = ls_tpl[k % ls_tpl.size()];
			push_ls(line_we[t] != 0, line_addr[t] + mem_req_pkg::addr_t'(k / ls_tpl.size()),
				line_data[t] + mem_req_pkg::word_t'(k / ls_tpl.size()));
			k++;
			if (fetch_full_at >= 0 && ls_full_at >= 0) settle++;
		end
		check_value("fetch_almost_full before fetch_full", 1,
			32'(fetch_af_at >= 0 && fetch_af_at < fetch_full_at));
		check_value("ls_almost_full before ls_full", 1, 32'(ls_af_at >= 0 && ls_af_at < ls_full_at));
		if (fetch_drops == 0 || ls_drops == 0) begin
			$display("the flood never pushed into a full queue on both ports");
			stop_with_failure();
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		int i;
		int a;
		int gap;
		rst = 1'b1;
		idle_inputs();
		for (a = 0; a < mem_req_pkg::RAM_DEPTH; a++) begin
			shadow[a] = '0;
		end
		read_stimulus();
		cycle_limit = 20 * line_port.size() + 200;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// Nothing is requested yet, so the outputs stay quiet
		repeat (10) begin
			@(negedge clk);
			check_value("fetch_rvalid", 0, 32'(fetch_rvalid));
			check_value("ls_rvalid", 0, 32'(ls_rvalid));
			check_value("fetch_full", 0, 32'(fetch_full));
			check_value("ls_full", 0, 32'(ls_full));
			check_value("fetch_almost_full", 0, 32'(fetch_almost_full));
			check_value("ls_almost_full", 0, 32'(ls_almost_full));
		end
		i = 0;
		while (i < line_port.size()) begin
			if (line_port[i] == 2) begin
				@(negedge clk);
				idle_inputs();
				wait_drained();
				i++;
			end else if (line_phase[i] == 3) begin
				run_flood(i);
			end else begin
				@(negedge clk);
				idle_inputs();
				issue_line(i);
				// Mixed traffic gets a few idle cycles between requests
				if (line_phase[i] == 2) begin
					gap = int'($unsigned($random(seed)) % 4);
					repeat (gap) begin
						@(negedge clk);
						idle_inputs();
					end
				end
				i++;
			end
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== verif/mem_req_input.txt ====
# phase port we addr data, with addr and data in hex
# port 0 is fetch, 1 is load/store, 2 closes the phase and ignores the other columns
1 0 0 3f0 00000000
1 1 1 100 a1000100
1 1 1 101 a1000101
1 1 1 102 a1000102
1 1 1 103 a1000103
1 1 1 020 c0de0020
1 1 1 021 c0de0021
1 1 0 020 00000000
1 2 0 000 00000000
2 0 0 100 00000000
2 1 0 020 00000000
2 0 0 101 00000000
2 1 1 022 0badf00d
2 1 0 022 00000000
2 0 0 102 00000000
2 1 0 021 00000000
2 0 0 103 00000000
2 1 1 020 12345678
2 0 0 3f0 00000000
2 1 0 020 00000000
2 0 0 021 00000000
2 1 0 100 00000000
2 2 0 000 00000000
3 0 0 100 00000000
3 1 1 200 f1000000
3 1 0 200 00000000
3 2 0 000 00000000

// ==== build.f ====
src/mem_req_pkg.sv
src/req_fifo.sv
src/req_arbiter.sv
src/local_ram.sv
src/mem_req_top.sv
verif/tb_mem_req.sv

// ==== Makefile ====
# Verilator flow for the memory request path

VERILATOR  ?= verilator
TOP        := tb_mem_req
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
FAIL_MSG   := test failed
PASS_MSG   := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
